//--- rtl/calib_pkg.sv
// Widths and APB register map; the map assumes at most 8 channels below CTRL_ADDR and DATA_WIDTH <= APB_DATA_WIDTH
package calib_pkg;

    // Stream widths, also the defaults of the module parameters
    localparam int DATA_WIDTH = 16;
    localparam int DEST_WIDTH = 2;
    localparam int USER_WIDTH = 8;

    // APB bus widths
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    // Gain is unsigned fixed point with this many fraction bits
    localparam int GAIN_FRAC_BITS = 14;
    localparam logic [DATA_WIDTH-1:0] UNITY_GAIN = DATA_WIDTH'(1 << GAIN_FRAC_BITS);

    // Channel c has its gain at 8*c and its offset at 8*c + 4
    localparam int CHANNEL_STRIDE_BITS = 3;
    localparam logic [2:0] GAIN_LOW_ADDR = 3'd0;
    localparam logic [2:0] OFFSET_LOW_ADDR = 3'd4;

    // Bit 0 of the control register is bypass
    localparam logic [APB_ADDR_WIDTH-1:0] CTRL_ADDR = 8'h40;
    localparam int CTRL_BYPASS_BIT = 0;

    typedef enum logic [1:0] {
        REG_GAIN,
        REG_OFFSET,
        REG_CTRL,
        REG_NONE
    } reg_select_e;

endpackage

//--- rtl/axi_stream.sv
// AXI-stream style link with dest, user and last; a master holds its outputs until valid and ready meet
`timescale 1ns/1ps

interface axi_stream import calib_pkg::*; #(
    parameter int DATA_WIDTH = calib_pkg::DATA_WIDTH,
    parameter int DEST_WIDTH = calib_pkg::DEST_WIDTH,
    parameter int USER_WIDTH = calib_pkg::USER_WIDTH
);

    logic                  valid;
    logic                  ready;
    logic [DATA_WIDTH-1:0] data;
    logic [DEST_WIDTH-1:0] dest;
    logic [USER_WIDTH-1:0] user;
    logic                  last;

    modport master (
        output valid, data, dest, user, last,
        input  ready
    );

    modport slave (
        input  valid, data, dest, user, last,
        output ready
    );

endinterface

//--- rtl/register_slice.sv
// Pipeline of N_STAGES (at least 1) stream registers that all freeze while out.ready is low; in.ready is combinational
`timescale 1ns/1ps

module register_slice import calib_pkg::*; #(
    parameter int DATA_WIDTH = calib_pkg::DATA_WIDTH,
    parameter int DEST_WIDTH = calib_pkg::DEST_WIDTH,
    parameter int USER_WIDTH = calib_pkg::USER_WIDTH,
    parameter int N_STAGES   = 1
) (
    input logic       clock,
    input logic       reset,
    axi_stream.slave  in,
    axi_stream.master out
);

    logic [DATA_WIDTH-1:0] data_q [N_STAGES];
    logic [DEST_WIDTH-1:0] dest_q [N_STAGES];
    logic [USER_WIDTH-1:0] user_q [N_STAGES];
    logic [N_STAGES-1:0]   last_q;
    logic [N_STAGES-1:0]   valid_q;

    // The whole chain moves as one, so ready needs no buffering
    assign in.ready = out.ready;

    assign out.valid = valid_q[N_STAGES-1];
    assign out.data  = data_q[N_STAGES-1];
    assign out.dest  = dest_q[N_STAGES-1];
    assign out.user  = user_q[N_STAGES-1];
    assign out.last  = last_q[N_STAGES-1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_q <= '0;
            last_q  <= '0;
            for (int i = 0; i < N_STAGES; i++) begin
                data_q[i] <= '0;
                dest_q[i] <= '0;
                user_q[i] <= '0;
            end
        end else if (out.ready) begin
            valid_q[0] <= in.valid;
            last_q[0]  <= in.last;
            data_q[0]  <= in.data;
            dest_q[0]  <= in.dest;
            user_q[0]  <= in.user;
            for (int i = 1; i < N_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
                last_q[i]  <= last_q[i-1];
                data_q[i]  <= data_q[i-1];
                dest_q[i]  <= dest_q[i-1];
                user_q[i]  <= user_q[i-1];
            end
        end
        // Otherwise every stage holds, bubbles included
    end

endmodule

//--- rtl/calibration_regs.sv
// APB slave with no wait states; registers are DATA_WIDTH bits and read back zero-extended, unmapped accesses set pslverr
`timescale 1ns/1ps

module calibration_regs import calib_pkg::*; #(
    parameter int DATA_WIDTH = calib_pkg::DATA_WIDTH,
    parameter int DEST_WIDTH = calib_pkg::DEST_WIDTH
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        psel,
    input  logic                                        penable,
    input  logic                                        pwrite,
    input  logic [APB_ADDR_WIDTH-1:0]                   paddr,
    input  logic [APB_DATA_WIDTH-1:0]                   pwdata,
    output logic [APB_DATA_WIDTH-1:0]                   prdata,
    output logic                                        pready,
    output logic                                        pslverr,
    output logic [2**DEST_WIDTH-1:0][DATA_WIDTH-1:0]    gain_table,
    output logic [2**DEST_WIDTH-1:0][DATA_WIDTH-1:0]    offset_table,
    output logic                                        bypass
);

    reg_select_e               reg_select;
    logic [DEST_WIDTH-1:0]     channel;
    logic [APB_DATA_WIDTH-1:0] read_value;

    assign pready  = 1'b1;
    assign channel = paddr[CHANNEL_STRIDE_BITS +: DEST_WIDTH];

    // Only the low 8*channels bytes hold per-channel registers
    always_comb begin
        reg_select = REG_NONE;
        if (paddr == CTRL_ADDR) begin
            reg_select = REG_CTRL;
        end else if ((paddr >> (CHANNEL_STRIDE_BITS + DEST_WIDTH)) == '0) begin
            if (paddr[2:0] == GAIN_LOW_ADDR) begin
                reg_select = REG_GAIN;
            end else if (paddr[2:0] == OFFSET_LOW_ADDR) begin
                reg_select = REG_OFFSET;
            end
        end
    end

    always_comb begin
        read_value = '0;
        case (reg_select)
            REG_GAIN:   read_value[DATA_WIDTH-1:0] = gain_table[channel];
            REG_OFFSET: read_value[DATA_WIDTH-1:0] = offset_table[channel];
            REG_CTRL:   read_value[CTRL_BYPASS_BIT] = bypass;
            default:    read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int c = 0; c < 2**DEST_WIDTH; c++) begin
                gain_table[c]   <= DATA_WIDTH'(UNITY_GAIN);
                offset_table[c] <= '0;
            end
            bypass  <= 1'b0;
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            if (psel && penable && pwrite) begin
                case (reg_select)
                    REG_GAIN:   gain_table[channel] <= pwdata[DATA_WIDTH-1:0];
                    REG_OFFSET: offset_table[channel] <= pwdata[DATA_WIDTH-1:0];
                    REG_CTRL:   bypass <= pwdata[CTRL_BYPASS_BIT];
                    default:    ;
                endcase
            end
            // Response is captured in the setup phase and held through the access phase
            if (psel && !penable) begin
                prdata  <= pwrite ? '0 : read_value;
                pslverr <= (reg_select == REG_NONE);
            end else if (psel && penable) begin
                prdata  <= '0;
                pslverr <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/sample_calibrator.sv
// One stall-aware stage computing sat(floor(data*gain/2^GAIN_FRAC_BITS) + offset); gain is unsigned, offset signed
`timescale 1ns/1ps

module sample_calibrator import calib_pkg::*; #(
    parameter int DATA_WIDTH = calib_pkg::DATA_WIDTH,
    parameter int DEST_WIDTH = calib_pkg::DEST_WIDTH,
    parameter int USER_WIDTH = calib_pkg::USER_WIDTH
) (
    input logic                                     clock,
    input logic                                     reset,
    axi_stream.slave                                in,
    axi_stream.master                               out,
    input logic [2**DEST_WIDTH-1:0][DATA_WIDTH-1:0] gain_table,
    input logic [2**DEST_WIDTH-1:0][DATA_WIDTH-1:0] offset_table,
    input logic                                     bypass
);

    // Wide enough for the full product plus the offset without overflow
    localparam int CALC_WIDTH = 2 * DATA_WIDTH + 2;
    localparam logic signed [CALC_WIDTH-1:0] SAT_MAX =
        {{(CALC_WIDTH - DATA_WIDTH + 1){1'b0}}, {(DATA_WIDTH - 1){1'b1}}};
    localparam logic signed [CALC_WIDTH-1:0] SAT_MIN =
        {{(CALC_WIDTH - DATA_WIDTH + 1){1'b1}}, {(DATA_WIDTH - 1){1'b0}}};

    logic [DATA_WIDTH-1:0]        gain;
    logic signed [DATA_WIDTH-1:0] offset;
    logic signed [CALC_WIDTH-1:0] product;
    logic signed [CALC_WIDTH-1:0] scaled;
    logic signed [CALC_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0]        result;

    assign in.ready = out.ready;

    always_comb begin
        gain   = gain_table[in.dest];
        offset = $signed(offset_table[in.dest]);
        // A zero is prepended so the gain stays positive in the signed multiply
        product = $signed(in.data) * $signed({1'b0, gain});
        // Arithmetic shift rounds toward minus infinity
        scaled = product >>> GAIN_FRAC_BITS;
        sum    = scaled + offset;
        if (bypass) begin
            result = in.data;
        end else if (sum > SAT_MAX) begin
            result = SAT_MAX[DATA_WIDTH-1:0];
        end else if (sum < SAT_MIN) begin
            result = SAT_MIN[DATA_WIDTH-1:0];
        end else begin
            result = sum[DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            out.valid <= 1'b0;
        end else if (out.ready) begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (out.ready) begin
            out.data <= result;
            out.dest <= in.dest;
            out.user <= in.user;
            out.last <= in.last;
        end
    end

endmodule

//--- rtl/calibration_chain.sv
// Slice, calibrator, slice; latency is 2*N_STAGES+1 accepted edges and out_ready reaches in_ready combinationally
`timescale 1ns/1ps

module calibration_chain import calib_pkg::*; #(
    parameter int N_STAGES = 2
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [DATA_WIDTH-1:0]     in_data,
    input  logic [DEST_WIDTH-1:0]     in_dest,
    input  logic [USER_WIDTH-1:0]     in_user,
    input  logic                      in_last,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic [DEST_WIDTH-1:0]     out_dest,
    output logic [USER_WIDTH-1:0]     out_user,
    output logic                      out_last,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [APB_DATA_WIDTH-1:0] pwdata,
    output logic [APB_DATA_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic [2**DEST_WIDTH-1:0][DATA_WIDTH-1:0] gain_table;
    logic [2**DEST_WIDTH-1:0][DATA_WIDTH-1:0] offset_table;
    logic                                     bypass;

    // The outer two links only adapt the plain ports to the stream interface
    axi_stream #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH), .USER_WIDTH(USER_WIDTH))
        in_stream ();
    axi_stream #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH), .USER_WIDTH(USER_WIDTH))
        raw_stream ();
    axi_stream #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH), .USER_WIDTH(USER_WIDTH))
        cal_stream ();
    axi_stream #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH), .USER_WIDTH(USER_WIDTH))
        out_stream ();

    assign in_stream.valid = in_valid;
    assign in_stream.data  = in_data;
    assign in_stream.dest  = in_dest;
    assign in_stream.user  = in_user;
    assign in_stream.last  = in_last;
    assign in_ready        = in_stream.ready;

    assign out_valid        = out_stream.valid;
    assign out_data         = out_stream.data;
    assign out_dest         = out_stream.dest;
    assign out_user         = out_stream.user;
    assign out_last         = out_stream.last;
    assign out_stream.ready = out_ready;

    register_slice #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEST_WIDTH(DEST_WIDTH),
        .USER_WIDTH(USER_WIDTH),
        .N_STAGES  (N_STAGES)
    ) input_slice (
        .clock(clock),
        .reset(reset),
        .in   (in_stream.slave),
        .out  (raw_stream.master)
    );

    sample_calibrator #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEST_WIDTH(DEST_WIDTH),
        .USER_WIDTH(USER_WIDTH)
    ) calibrator (
        .clock       (clock),
        .reset       (reset),
        .in          (raw_stream.slave),
        .out         (cal_stream.master),
        .gain_table  (gain_table),
        .offset_table(offset_table),
        .bypass      (bypass)
    );

    register_slice #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEST_WIDTH(DEST_WIDTH),
        .USER_WIDTH(USER_WIDTH),
        .N_STAGES  (N_STAGES)
    ) output_slice (
        .clock(clock),
        .reset(reset),
        .in   (cal_stream.slave),
        .out  (out_stream.master)
    );

    calibration_regs #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEST_WIDTH(DEST_WIDTH)
    ) regs (
        .clock       (clock),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .gain_table  (gain_table),
        .offset_table(offset_table),
        .bypass      (bypass)
    );

endmodule

//--- tests/calibration_chain_asserts.sv
// Output stream and APB properties, bound into calibration_chain; stream checks are off in reset
`timescale 1ns/1ps

module calibration_chain_asserts import calib_pkg::*; (
    input logic                  clock,
    input logic                  reset,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic [DATA_WIDTH-1:0] out_data,
    input logic [DEST_WIDTH-1:0] out_dest,
    input logic [USER_WIDTH-1:0] out_user,
    input logic                  out_last,
    input logic                  pready
);

    int failure_count = 0;

    // A stalled output must keep its sample until it is taken
    hold_while_stalled: assert property (@(posedge clock) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest)
            && $stable(out_user) && $stable(out_last))
        else begin
            failure_count++;
            $error("output sample changed while out_ready was low");
        end

    // The slave never inserts wait states
    pready_high: assert property (@(posedge clock) pready)
        else begin
            failure_count++;
            $error("pready went low");
        end

    // Every valid register clears on reset
    valid_low_after_reset: assert property (@(posedge clock) !reset |=> !out_valid)
        else begin
            failure_count++;
            $error("out_valid high in the cycle after reset");
        end

endmodule

bind calibration_chain calibration_chain_asserts asserts (
    .clock    (clock),
    .reset    (reset),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_dest (out_dest),
    .out_user (out_user),
    .out_last (out_last),
    .pready   (pready)
);

//--- tests/calibration_chain_tb.sv
// Register writes happen only while the stream is empty; latency is counted in edges with out_ready high
`timescale 1ns/1ps

module calibration_chain_tb import calib_pkg::*; ();

    localparam int unsigned SEED = 32'h6fe4;
    localparam int CLOCK_PERIOD = 40;
    localparam int SAMPLE_COUNT = 300;
    localparam int ROUNDS = 3;
    localparam int LATENCY = 5;
    localparam int CHANNELS = 2 ** DEST_WIDTH;
    localparam int APB_ACCESSES = 128;
    localparam longint TIMEOUT = longint'(SAMPLE_COUNT) * LATENCY * CLOCK_PERIOD * 4
        + longint'(APB_ACCESSES) * 3 * CLOCK_PERIOD;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0] dest;
        logic [USER_WIDTH-1:0] user;
        logic                  last;
        int unsigned           stamp;
    } sample_t;

    logic clock;
    logic reset;
    logic in_valid, in_ready, in_last, out_valid, out_ready, out_last;
    logic [DATA_WIDTH-1:0] in_data, out_data;
    logic [DEST_WIDTH-1:0] in_dest, out_dest;
    logic [USER_WIDTH-1:0] in_user, out_user;
    logic psel, penable, pwrite, pready, pslverr;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata, prdata;

    logic [DATA_WIDTH-1:0] gain_mirror [CHANNELS];
    logic [DATA_WIDTH-1:0] offset_mirror [CHANNELS];
    logic bypass_mirror = 1'b0;
    logic random_ready = 1'b0;
    sample_t expected_q [$];
    int unsigned ready_edges = 0;
    int error_count = 0;
    int check_count = 0;
    int received_count = 0;

    calibration_chain #(.N_STAGES(2)) UUT (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic void report_mismatch(string what, logic [31:0] got, logic [31:0] expected);
        error_count++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    endfunction

    // Reference for the calibration rule, floor division by the gain scale
    function automatic logic [DATA_WIDTH-1:0] calibrate(logic [DATA_WIDTH-1:0] sample,
            logic [DATA_WIDTH-1:0] gain, logic [DATA_WIDTH-1:0] offset, logic bypass_on);
        longint divisor;
        longint value;
        longint limit_hi;
        longint limit_lo;
        divisor  = longint'(1) << GAIN_FRAC_BITS;
        limit_hi = (longint'(1) << (DATA_WIDTH - 1)) - 1;
        limit_lo = -(longint'(1) << (DATA_WIDTH - 1));
        if (bypass_on) begin
            return sample;
        end
        value = longint'($signed(sample)) * longint'(gain);
        if (value < 0 && (value % divisor) != 0) begin
            value = value / divisor - 1;
        end else begin
            value = value / divisor;
        end
        value = value + longint'($signed(offset));
        if (value > limit_hi) value = limit_hi;
        if (value < limit_lo) value = limit_lo;
        return value[DATA_WIDTH-1:0];
    endfunction

    // Scoreboard compares before pushing, so a sample can never meet itself
    always @(posedge clock) begin
        sample_t expected;
        sample_t accepted;
        if (reset && out_valid && expected_q.size() == 0) begin
            error_count++;
            $display("out_valid was high at %0t with no sample pending", $time);
        end else if (reset && out_valid && out_ready) begin
            expected = expected_q.pop_front();
            received_count++;
            check_count++;
            assert (out_data == expected.data)
                else report_mismatch("out_data", 32'(out_data), 32'(expected.data));
            assert (out_dest == expected.dest)
                else report_mismatch("out_dest", 32'(out_dest), 32'(expected.dest));
            assert (out_user == expected.user)
                else report_mismatch("out_user", 32'(out_user), 32'(expected.user));
            assert (out_last == expected.last)
                else report_mismatch("out_last", 32'(out_last), 32'(expected.last));
            assert (ready_edges - expected.stamp == LATENCY)
                else report_mismatch("latency", ready_edges - expected.stamp, 32'(LATENCY));
        end
        if (reset && in_valid && in_ready) begin
            accepted.data  = calibrate(in_data, gain_mirror[in_dest], offset_mirror[in_dest],
                                       bypass_mirror);
            accepted.dest  = in_dest;
            accepted.user  = in_user;
            accepted.last  = in_last;
            accepted.stamp = ready_edges;
            expected_q.push_back(accepted);
        end
        if (reset && out_ready) begin
            ready_edges++;
        end
    end

    always @(negedge clock) begin
        out_ready = random_ready ? 1'($urandom) : 1'b1;
    end

    task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
            input logic [APB_DATA_WIDTH-1:0] wdata, output logic [APB_DATA_WIDTH-1:0] rdata,
            output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        // The response was registered at the end of the setup phase
        rdata = prdata;
        err   = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_register(input logic [APB_ADDR_WIDTH-1:0] addr,
            input logic [APB_DATA_WIDTH-1:0] value);
        logic [APB_DATA_WIDTH-1:0] rdata;
        logic err;
        apb_access(1'b1, addr, value, rdata, err);
        check_count++;
        assert (!err) else report_mismatch($sformatf("pslverr on write to %0h", addr), 32'(err), 0);
    endtask

    task automatic read_check(input logic [APB_ADDR_WIDTH-1:0] addr,
            input logic [APB_DATA_WIDTH-1:0] expected, input logic expected_err);
        logic [APB_DATA_WIDTH-1:0] rdata;
        logic err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_count++;
        assert (rdata == expected)
            else report_mismatch($sformatf("prdata at %0h", addr), rdata, expected);
        assert (err == expected_err)
            else report_mismatch($sformatf("pslverr at %0h", addr), 32'(err), 32'(expected_err));
    endtask

    task automatic unmapped_check(input logic [APB_ADDR_WIDTH-1:0] addr);
        logic [APB_DATA_WIDTH-1:0] rdata;
        logic err;
        apb_access(1'b1, addr, '1, rdata, err);
        check_count++;
        assert (err) else report_mismatch($sformatf("pslverr on write to %0h", addr), 32'(err), 1);
        read_check(addr, '0, 1'b1);
    endtask

    task automatic randomize_registers();
        for (int c = 0; c < CHANNELS; c++) begin
            gain_mirror[c]   = DATA_WIDTH'($urandom);
            offset_mirror[c] = DATA_WIDTH'($urandom);
            write_register(APB_ADDR_WIDTH'(8 * c), APB_DATA_WIDTH'(gain_mirror[c]));
            write_register(APB_ADDR_WIDTH'(8 * c + 4), APB_DATA_WIDTH'(offset_mirror[c]));
        end
        for (int c = 0; c < CHANNELS; c++) begin
            read_check(APB_ADDR_WIDTH'(8 * c), APB_DATA_WIDTH'(gain_mirror[c]), 1'b0);
            read_check(APB_ADDR_WIDTH'(8 * c + 4), APB_DATA_WIDTH'(offset_mirror[c]), 1'b0);
        end
    endtask

    task automatic send_samples(input int count, input logic gaps);
        int idle;
        for (int i = 0; i < count; i++) begin
            idle = gaps ? int'($urandom_range(0, 3)) : 0;
            repeat (idle) begin
                @(negedge clock);
                in_valid = 1'b0;
            end
            @(negedge clock);
            in_valid = 1'b1;
            in_data  = DATA_WIDTH'($urandom);
            in_dest  = DEST_WIDTH'($urandom);
            in_user  = USER_WIDTH'($urandom);
            in_last  = 1'($urandom);
            do @(posedge clock); while (!in_ready);
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic drain_stream();
        while (expected_q.size() != 0) @(negedge clock);
        @(negedge clock);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Run timed out after %0t with %0d samples still pending", $time,
                 expected_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b0;
        {in_valid, in_data, in_dest, in_user, in_last} = '0;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        out_ready = 1'b1;
        for (int c = 0; c < CHANNELS; c++) begin
            gain_mirror[c]   = UNITY_GAIN;
            offset_mirror[c] = '0;
        end
        repeat (2) @(negedge clock);
        reset = 1'b1;

        // Reset values, and the monitor flags any output before a sample is sent
        for (int c = 0; c < CHANNELS; c++) begin
            read_check(APB_ADDR_WIDTH'(8 * c), APB_DATA_WIDTH'(UNITY_GAIN), 1'b0);
            read_check(APB_ADDR_WIDTH'(8 * c + 4), '0, 1'b0);
        end
        read_check(CTRL_ADDR, '0, 1'b0);
        repeat (8) @(negedge clock);

        // Address 01 sits inside the channel 0 gain slot, so a bad decode would show here
        unmapped_check(8'h01);
        unmapped_check(8'h20);
        unmapped_check(8'h44);
        read_check(8'h00, APB_DATA_WIDTH'(UNITY_GAIN), 1'b0);

        for (int round = 0; round < ROUNDS; round++) begin
            if (round == ROUNDS - 1) begin
                bypass_mirror = 1'b1;
                write_register(CTRL_ADDR, 32'd1);
                read_check(CTRL_ADDR, 32'd1, 1'b0);
            end
            randomize_registers();
            random_ready = (round != 0);
            send_samples(SAMPLE_COUNT / ROUNDS, round != 0);
            drain_stream();
            random_ready = 1'b0;
        end

        error_count += UUT.asserts.failure_count;
        $display("Samples received: %0d, checks: %0d, errors: %0d", received_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- calibration_chain.f
rtl/calib_pkg.sv
rtl/axi_stream.sv
rtl/register_slice.sv
rtl/calibration_regs.sv
rtl/sample_calibrator.sv
rtl/calibration_chain.sv
tests/calibration_chain_asserts.sv
tests/calibration_chain_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= calibration_chain_tb
FILELIST  ?= calibration_chain.f
BUILD_DIR ?= obj_dir
LOG       ?= simulate.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
